//--- sim/gate_cases.txt
# packet read_flag address write_data, all hex
# lines of one packet are consecutive; write_data is sent but unused for reads
0 0 000010 11223344
0 1 000010 00000000
1 1 000020 00000000
1 0 000020 cafef00d
1 1 000020 00000000
1 1 abcdef 00000000
2 0 123456 a5a5a5a5
2 0 123458 5a5a5a5a
2 1 123456 00000000
2 1 123458 00000000
3 1 000010 00000000
4 0 ffffff 01020304
4 1 ffffff 00000000
4 0 000010 deadbeef
4 1 000010 00000000
5 1 00ff00 00000000
5 0 00ff00 13572468
6 1 00ff00 00000000

//--- src.f
+incdir+hw
hw/stream_pkg.sv
hw/lb_pkg.sv
hw/sync_fifo.sv
hw/cmd_deframer.sv
hw/wb_xact_master.sv
hw/reply_framer.sv
hw/udp_lb_gate.sv
sim/udp_lb_gate_tb.sv

//--- Bender.yml
package:
  name: udp_lb_gate

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/stream_pkg.sv
      - hw/lb_pkg.sv
      - hw/sync_fifo.sv
      - hw/cmd_deframer.sv
      - hw/wb_xact_master.sv
      - hw/reply_framer.sv
      - hw/udp_lb_gate.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/udp_lb_gate_tb.sv

//--- sim/udp_lb_gate_tb.sv
`include "gate_defines.svh"

module udp_lb_gate_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int drain_limit = 2000;
	localparam int store_size = 64;

	logic clk = 1'b0;
	logic rst_n;
	logic [7:0] rx_data;
	logic rx_valid;
	logic rx_end;
	logic [7:0] tx_data;
	logic tx_valid;
	logic tx_last;
	logic tx_ready;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`GATE_ADDR_W-1:0] wb_adr;
	logic [`GATE_DATA_W-1:0] wb_dat_o;
	logic [`GATE_DATA_W/8-1:0] wb_sel;
	logic [`GATE_DATA_W-1:0] wb_dat_i;
	logic wb_ack;

	// Cases as read from the data file
	int case_pkt[$];
	logic case_rd[$];
	logic [23:0] case_addr[$];
	logic [31:0] case_wdata[$];

	// Expected reply bytes as {data, last} with a name per byte
	logic [8:0] exp_beat[$];
	string exp_name[$];

	// Word stores
	// Bank 0 is the reference model and bank 1 the bus memory
	logic [23:0] st_addr[2][store_size];
	logic [31:0] st_data[2][store_size];
	int st_count[2];

	int mismatches;
	int proto_errors;
	int timeouts;
	int stray_bytes;
	int setup_errors;

	udp_lb_gate i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_end(rx_end),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_last(tx_last),
		.tx_ready(tx_ready),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o),
		.wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack)
	);

	// 4 ns clock period
	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Unwritten words read as address XOR 5A5A0000
	function automatic logic [31:0] store_read(input int bank, input logic [23:0] addr);
		logic [31:0] val;
		int i;
		val = {8'h00, addr} ^ 32'h5A5A_0000;
		for (i = 0; i < st_count[bank]; i++) begin
			if (st_addr[bank][i] == addr) begin
				val = st_data[bank][i];
			end
		end
		return val;
	endfunction

	function automatic void store_write(input int bank, input logic [23:0] addr,
			input logic [31:0] data);
		int i;
		int hit;
		hit = -1;
		for (i = 0; i < st_count[bank]; i++) begin
			if (st_addr[bank][i] == addr) begin
				hit = i;
			end
		end
		if (hit >= 0) begin
			st_data[bank][hit] = data;
		end else if (st_count[bank] < store_size) begin
			st_addr[bank][st_count[bank]] = addr;
			st_data[bank][st_count[bank]] = data;
			st_count[bank]++;
		end
	endfunction

	// Nonce pattern from the packet number
	function automatic logic [63:0] make_nonce(input int p);
		logic [7:0] pb;
		pb = p[7:0];
		return {8'hA5, pb, 8'h3C, ~pb, 8'h5A ^ pb, 8'h0F, pb + 8'h11, 8'hC3};
	endfunction

	// Control word with read flag, slot index in bits 27..24 and address
	function automatic logic [31:0] make_ctl(input logic rd, input int idx,
			input logic [23:0] addr);
		logic [31:0] ctl;
		ctl = '0;
		ctl[`GATE_READ_BIT] = rd;
		ctl[27:24] = idx[3:0];
		ctl[23:0] = addr;
		return ctl;
	endfunction

	function automatic void push_expect(input logic [7:0] data, input logic last,
			input string name);
		exp_beat.push_back({data, last});
		exp_name.push_back(name);
	endfunction

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		#0.5;
		rx_data = b;
		rx_valid = 1'b1;
	endtask

	// Lines starting with # are skipped
	task automatic load_cases();
		int fd;
		int code;
		int lines;
		bit done;
		string skip;
		logic [31:0] f_pkt;
		logic [31:0] f_rd;
		logic [31:0] f_addr;
		logic [31:0] f_wdata;
		fd = $fopen("sim/gate_cases.txt", "r");
		if (fd == 0) begin
			setup_errors++;
			$display("ERROR: cannot open sim/gate_cases.txt");
		end else begin
			lines = 0;
			done = 1'b0;
			while (!done && lines < 1000) begin
				lines++;
				code = $fscanf(fd, "%h %h %h %h", f_pkt, f_rd, f_addr, f_wdata);
				if (code == 4) begin
					case_pkt.push_back(int'(f_pkt));
					case_rd.push_back(f_rd[0]);
					case_addr.push_back(f_addr[23:0]);
					case_wdata.push_back(f_wdata);
				end else if (code < 0) begin
					done = 1'b1;
				end else begin
					code = $fgets(skip, fd);
				end
			end
			$fclose(fd);
		end
	endtask

	// Builds the expected reply of one packet, sends the packet and waits for the reply
	task automatic run_packet(input int first, input int count, output bit timed_out);
		int p;
		int k;
		int b;
		int waited;
		logic [63:0] nonce;
		logic [31:0] ctl;
		logic [31:0] res;
		logic [63:0] word;
		string kind;
		p = case_pkt[first];
		nonce = make_nonce(p);
		for (b = 0; b < 8; b++) begin
			push_expect(nonce[63 - 8*b -: 8], 1'b0,
				$sformatf("pkt%0d nonce byte%0d", p, b));
		end
		for (k = 0; k < count; k++) begin
			ctl = make_ctl(case_rd[first + k], k, case_addr[first + k]);
			// Reads see earlier writes of the same packet stream in order
			if (case_rd[first + k]) begin
				res = store_read(0, case_addr[first + k]);
				kind = "read";
			end else begin
				res = case_wdata[first + k];
				store_write(0, case_addr[first + k], res);
				kind = "write";
			end
			for (b = 0; b < 4; b++) begin
				push_expect(ctl[31 - 8*b -: 8], 1'b0,
					$sformatf("pkt%0d xact%0d %s ctl byte%0d", p, k, kind, b));
			end
			// Last flag only on the final byte of the packet's reply
			for (b = 0; b < 4; b++) begin
				push_expect(res[31 - 8*b -: 8], (k == count - 1) && (b == 3),
					$sformatf("pkt%0d xact%0d %s result byte%0d", p, k, kind, b));
			end
		end
		for (b = 0; b < 8; b++) begin
			send_byte(nonce[63 - 8*b -: 8]);
		end
		for (k = 0; k < count; k++) begin
			word = {make_ctl(case_rd[first + k], k, case_addr[first + k]),
				case_wdata[first + k]};
			for (b = 0; b < 8; b++) begin
				send_byte(word[63 - 8*b -: 8]);
			end
		end
		// End pulse right after the last byte
		@(posedge clk);
		#0.5;
		rx_valid = 1'b0;
		rx_data = '0;
		rx_end = 1'b1;
		@(posedge clk);
		#0.5;
		rx_end = 1'b0;
		waited = 0;
		while (exp_beat.size() != 0 && waited < drain_limit) begin
			@(posedge clk);
			waited++;
		end
		timed_out = (exp_beat.size() != 0);
		if (timed_out) begin
			timeouts++;
			$display("ERROR: reply of packet %0d still missing %0d bytes after %0d cycles",
				p, exp_beat.size(), drain_limit);
		end
	endtask

	// Random tx_ready that is high about 60 percent of the time
	initial begin : ready_drive
		logic [31:0] rs;
		rs = 32'd88;
		forever begin
			@(posedge clk);
			#0.5;
			if (rst_n) begin
				rs = lcg_next(rs);
				tx_ready = (rs[31:28] >= 4'd6);
			end
		end
	end

	// Reply checker sampled mid-cycle where tx outputs are stable
	always @(negedge clk) begin : tx_check
		logic [8:0] want;
		string name;
		if (rst_n && !tx_valid) begin
			assert (!tx_last) else begin
				proto_errors++;
				$display("ERROR: tx_last high while tx_valid is low at %0t", $time);
			end
		end
		if (rst_n && tx_valid && tx_ready) begin
			assert (exp_beat.size() != 0) else begin
				stray_bytes++;
				$display("ERROR: reply byte %h arrived when no byte was expected", tx_data);
			end
			if (exp_beat.size() != 0) begin
				want = exp_beat.pop_front();
				name = exp_name.pop_front();
				assert ({tx_data, tx_last} == want) else begin
					mismatches++;
					$display("FAIL %s expected %h last %b actual %h last %b",
						name, want[8:1], want[0], tx_data, tx_last);
				end
			end
		end
	end

	// Wishbone slave memory with random wait states
	initial begin : wb_slave
		logic [31:0] rs;
		int wait_left;
		bit in_cycle;
		bit ack_seen;
		logic [`GATE_ADDR_W-1:0] cap_adr;
		logic [`GATE_DATA_W-1:0] cap_dat;
		logic cap_we;
		rs = 32'd88;
		wait_left = 0;
		in_cycle = 1'b0;
		ack_seen = 1'b0;
		forever begin
			@(negedge clk);
			if (rst_n) begin
				assert (wb_cyc == wb_stb) else begin
					proto_errors++;
					$display("ERROR: wb_cyc and wb_stb differ at %0t", $time);
				end
				if (ack_seen) begin
					assert (!wb_cyc) else begin
						proto_errors++;
						$display("ERROR: wb_cyc still high the cycle after ack");
					end
					ack_seen = 1'b0;
				end
				// Bus outputs frozen from start of cycle until ack
				if (in_cycle) begin
					assert (wb_cyc && wb_adr == cap_adr && wb_we == cap_we
							&& wb_dat_o == cap_dat && wb_sel == '1) else begin
						proto_errors++;
						$display("ERROR: Wishbone outputs changed before ack at %0t", $time);
					end
				end
				if (wb_ack) begin
					// Ack is taken at the coming edge
					@(posedge clk);
					#0.5;
					wb_ack = 1'b0;
					in_cycle = 1'b0;
					ack_seen = 1'b1;
				end else if (wb_cyc) begin
					if (!in_cycle) begin
						cap_adr = wb_adr;
						cap_dat = wb_dat_o;
						cap_we = wb_we;
						in_cycle = 1'b1;
						rs = lcg_next(rs);
						wait_left = int'(rs[31:29]);
					end
					if (wait_left == 0) begin
						@(posedge clk);
						#0.5;
						// Writes put junk on dat_i so the master must return its own data
						if (cap_we) begin
							store_write(1, cap_adr, cap_dat);
							wb_dat_i = ~cap_dat;
						end else begin
							wb_dat_i = store_read(1, cap_adr);
						end
						wb_ack = 1'b1;
					end else begin
						wait_left--;
					end
				end
			end
		end
	end

	initial begin : main_flow
		int first;
		int count;
		bit abort;
		rst_n = 1'b0;
		rx_data = '0;
		rx_valid = 1'b0;
		rx_end = 1'b0;
		tx_ready = 1'b0;
		wb_dat_i = '0;
		wb_ack = 1'b0;
		abort = 1'b0;
		load_cases();
		if (case_pkt.size() == 0) begin
			setup_errors++;
			$display("ERROR: no cases were read from the data file");
		end
		repeat (3) @(posedge clk);
		#0.5;
		rst_n = 1'b1;
		@(negedge clk);
		assert (!wb_cyc && !wb_stb && !wb_we && !tx_valid && !tx_last) else begin
			proto_errors++;
			$display("ERROR: bus or transmit outputs not idle after reset");
		end
		// Group consecutive lines with the same packet number
		first = 0;
		while (first < case_pkt.size() && !abort) begin
			count = 1;
			while (first + count < case_pkt.size()
					&& case_pkt[first + count] == case_pkt[first]) begin
				count++;
			end
			if (count > `GATE_MAX_XACT) begin
				setup_errors++;
				$display("ERROR: packet %0d has %0d transactions, more than allowed",
					case_pkt[first], count);
				abort = 1'b1;
			end else begin
				run_packet(first, count, abort);
			end
			first += count;
		end
		// Quiet tail to catch stray bytes
		repeat (30) @(posedge clk);
		$display("Errors: %0d mismatches, %0d protocol, %0d timeouts, %0d stray, %0d setup",
			mismatches, proto_errors, timeouts, stray_bytes, setup_errors);
		if (mismatches + proto_errors + timeouts + stray_bytes + setup_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- hw/udp_lb_gate.sv
`include "gate_defines.svh"

module udp_lb_gate (
	input logic clk,
	input logic rst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic rx_end,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic tx_last,
	input logic tx_ready,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`GATE_ADDR_W-1:0] wb_adr,
	output logic [`GATE_DATA_W-1:0] wb_dat_o,
	output logic [`GATE_DATA_W/8-1:0] wb_sel,
	input logic [`GATE_DATA_W-1:0] wb_dat_i,
	input logic wb_ack
);
	import stream_pkg::*;
	import lb_pkg::*;

	// Nonce loopback
	byte_beat_t echo_beat;
	logic echo_valid;

	// Records from the deframer
	lb_header_t hdr_rec;
	lb_xact_t xact_rec;
	logic rec_valid;

	// Header path
	lb_header_t hdr_head;
	logic hdr_empty;
	logic hdr_pop;

	// Transaction path
	lb_xact_t xact_head;
	logic xact_empty;
	logic xact_pop;

	// Result path
	lb_result_t result_in;
	logic result_push;
	logic result_full;
	lb_result_t result_head;
	logic result_empty;
	logic result_pop;

	cmd_deframer u_deframer (
		.clk(clk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_end(rx_end),
		.echo_beat(echo_beat),
		.echo_valid(echo_valid),
		.hdr_rec(hdr_rec),
		.xact_rec(xact_rec),
		.rec_valid(rec_valid)
	);

	// Echoed control words wait here for their results
	sync_fifo #(
		.payload_t(lb_header_t),
		.depth(`GATE_MAX_XACT)
	) u_hdr_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(rec_valid),
		.wr_data(hdr_rec),
		.rd_en(hdr_pop),
		.rd_data(hdr_head),
		.full(),
		.empty(hdr_empty),
		.almost_full()
	);

	sync_fifo #(
		.payload_t(lb_xact_t),
		.depth(`GATE_XACT_DEPTH)
	) u_xact_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(rec_valid),
		.wr_data(xact_rec),
		.rd_en(xact_pop),
		.rd_data(xact_head),
		.full(),
		.empty(xact_empty),
		.almost_full()
	);

	wb_xact_master u_master (
		.clk(clk),
		.rst_n(rst_n),
		.xact(xact_head),
		.xact_valid(!xact_empty),
		.xact_pop(xact_pop),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o),
		.wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.result(result_in),
		.result_push(result_push),
		.result_full(result_full)
	);

	sync_fifo #(
		.payload_t(lb_result_t),
		.depth(`GATE_MAX_XACT)
	) u_result_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(result_push),
		.wr_data(result_in),
		.rd_en(result_pop),
		.rd_data(result_head),
		.full(result_full),
		.empty(result_empty),
		.almost_full()
	);

	reply_framer u_framer (
		.clk(clk),
		.rst_n(rst_n),
		.echo_beat(echo_beat),
		.echo_valid(echo_valid),
		.hdr(hdr_head),
		.hdr_valid(!hdr_empty),
		.result(result_head),
		.result_valid(!result_empty),
		.hdr_pop(hdr_pop),
		.result_pop(result_pop),
		.tx_ready(tx_ready),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_last(tx_last)
	);

endmodule

//--- hw/reply_framer.sv
`include "gate_defines.svh"

module reply_framer (
	input logic clk,
	input logic rst_n,
	input stream_pkg::byte_beat_t echo_beat,
	input logic echo_valid,
	input lb_pkg::lb_header_t hdr,
	input logic hdr_valid,
	input lb_pkg::lb_result_t result,
	input logic result_valid,
	output logic hdr_pop,
	output logic result_pop,
	input logic tx_ready,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic tx_last
);
	import stream_pkg::*;

	localparam int word_w = 2 * `GATE_DATA_W;

	logic [word_w-1:0] word_sr;
	logic word_last;
	logic [2:0] ser_cnt;
	logic ser_active;
	logic ser_go;
	logic start;
	logic reply_wr;
	byte_beat_t reply_in;
	byte_beat_t reply_out;
	logic reply_rd;
	logic reply_full;
	logic reply_empty;
	logic reply_afull;

	// New word only with room for all eight bytes
	assign start = !ser_active && hdr_valid && result_valid && !reply_afull;
	assign hdr_pop = start;
	assign result_pop = start;

	// Serializer yields to nonce bytes and waits on a full FIFO
	assign ser_go = ser_active && !echo_valid && !reply_full;

	// Byte into the reply FIFO
	assign reply_wr = echo_valid || ser_go;

	always_comb begin
		if (echo_valid) begin
			reply_in = echo_beat;
		end else begin
			// MSB first with the last flag only on the final byte of the last word
			reply_in.data = word_sr[word_w-1 -: 8];
			reply_in.last = word_last && (&ser_cnt);
		end
	end

	// Serializer control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ser_active <= 1'b0;
			ser_cnt <= '0;
		end else begin
			if (start) begin
				ser_active <= 1'b1;
				ser_cnt <= '0;
			end else if (ser_go) begin
				ser_cnt <= ser_cnt + 3'd1;
				if (&ser_cnt) begin
					ser_active <= 1'b0;
				end
			end
		end
	end

	// Header word on top and result word below
	always_ff @(posedge clk) begin
		if (start) begin
			word_sr <= {hdr.ctl, result.data};
			word_last <= hdr.last;
		end else if (ser_go) begin
			word_sr <= {word_sr[word_w-9:0], 8'h00};
		end
	end

	sync_fifo #(
		.payload_t(byte_beat_t),
		.depth(`GATE_REPLY_DEPTH)
	) u_reply_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(reply_wr),
		.wr_data(reply_in),
		.rd_en(reply_rd),
		.rd_data(reply_out),
		.full(reply_full),
		.empty(reply_empty),
		.almost_full(reply_afull)
	);

	// Transmit side straight off the FIFO head
	assign tx_valid = !reply_empty;
	assign tx_data = reply_out.data;
	assign tx_last = reply_out.last && !reply_empty;
	assign reply_rd = tx_valid && tx_ready;

endmodule

//--- hw/wb_xact_master.sv
`include "gate_defines.svh"

module wb_xact_master (
	input logic clk,
	input logic rst_n,
	input lb_pkg::lb_xact_t xact,
	input logic xact_valid,
	output logic xact_pop,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`GATE_ADDR_W-1:0] wb_adr,
	output logic [`GATE_DATA_W-1:0] wb_dat_o,
	output logic [`GATE_DATA_W/8-1:0] wb_sel,
	input logic [`GATE_DATA_W-1:0] wb_dat_i,
	input logic wb_ack,
	output lb_pkg::lb_result_t result,
	output logic result_push,
	input logic result_full
);
	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t state;
	logic done;

	// Start only when the result has somewhere to go
	assign xact_pop = (state == ST_IDLE) && xact_valid && !result_full;

	// Cycle ends on the ack of the active cycle
	assign done = (state == ST_BUSY) && wb_ack;

	// Full-word transfers only
	assign wb_sel = '1;

	// Result is ready in the ack cycle
	// Writes return the data that went out on the bus
	assign result_push = done;
	assign result.data = wb_we ? wb_dat_o : wb_dat_i;

	// FSM and bus strobes
	// cyc and stb rise and fall together
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (xact_pop) begin
						state <= ST_BUSY;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= !xact.rd;
					end
				end
				ST_BUSY: begin
					if (wb_ack) begin
						state <= ST_IDLE;
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Address and data held for the whole cycle
	always_ff @(posedge clk) begin
		if (xact_pop) begin
			wb_adr <= xact.addr;
			wb_dat_o <= xact.wdata;
		end
	end

endmodule

//--- hw/cmd_deframer.sv
`include "gate_defines.svh"

module cmd_deframer (
	input logic clk,
	input logic rst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic rx_end,
	output stream_pkg::byte_beat_t echo_beat,
	output logic echo_valid,
	output lb_pkg::lb_header_t hdr_rec,
	output lb_pkg::lb_xact_t xact_rec,
	output logic rec_valid
);
	import stream_pkg::*;
	import lb_pkg::*;

	localparam int word_w = 2 * `GATE_DATA_W;

	logic [word_w-1:0] rx_sr;
	logic [2:0] byte_cnt;
	logic nonce_done;
	logic word_q;
	logic ev_valid;
	echo_kind_t ev_kind;
	logic [7:0] ev_byte;
	logic flush_end;
	lb_header_t pend_hdr;
	lb_xact_t pend_xact;
	logic pend_valid;

	// Split a full 64-bit transaction into bus fields
	function automatic lb_xact_t decode_xact(input logic [word_w-1:0] w);
		lb_xact_t x;
		x.rd = w[`GATE_DATA_W + `GATE_READ_BIT];
		x.addr = w[`GATE_DATA_W +: `GATE_ADDR_W];
		x.wdata = w[`GATE_DATA_W-1:0];
		x.ctl = w[word_w-1 -: `GATE_DATA_W];
		x.last = 1'b0;
		return x;
	endfunction

	// Big-endian shift register with the newest byte at the bottom
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			rx_sr <= {rx_sr[word_w-9:0], rx_data};
		end
	end

	// Byte phase within the current 8-byte group
	// nonce_done goes high once the first group has passed
	// word_q pulses when rx_sr holds a whole transaction
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			nonce_done <= 1'b0;
			word_q <= 1'b0;
		end else begin
			word_q <= rx_valid && nonce_done && (&byte_cnt);
			if (rx_end) begin
				byte_cnt <= '0;
				nonce_done <= 1'b0;
			end else if (rx_valid) begin
				byte_cnt <= byte_cnt + 3'd1;
				if (&byte_cnt) begin
					nonce_done <= 1'b1;
				end
			end
		end
	end

	// Event stage one cycle behind the receive port
	// Nonce bytes and packet end share it so they stay in order
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ev_valid <= 1'b0;
			ev_kind <= ECHO_NONCE;
		end else begin
			ev_valid <= rx_end || (rx_valid && !nonce_done);
			ev_kind <= rx_end ? ECHO_END : ECHO_NONCE;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			ev_byte <= rx_data;
		end
	end

	// Nonce loopback toward the framer
	assign echo_valid = ev_valid && (ev_kind == ECHO_NONCE);
	assign echo_beat.data = ev_byte;
	assign echo_beat.last = 1'b0;

	// End of packet releases the held record with last set
	assign flush_end = ev_valid && (ev_kind == ECHO_END);

	// Hold-back slot control
	// A new transaction pushes out the one before it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pend_valid <= 1'b0;
			rec_valid <= 1'b0;
		end else begin
			rec_valid <= (word_q || flush_end) && pend_valid;
			if (word_q) begin
				pend_valid <= 1'b1;
			end else if (flush_end) begin
				pend_valid <= 1'b0;
			end
		end
	end

	// Hold-back slot and output records
	always_ff @(posedge clk) begin
		if (word_q) begin
			hdr_rec <= pend_hdr;
			xact_rec <= pend_xact;
			pend_hdr.ctl <= rx_sr[word_w-1 -: `GATE_DATA_W];
			pend_hdr.last <= 1'b0;
			pend_xact <= decode_xact(rx_sr);
		end else if (flush_end) begin
			hdr_rec <= pend_hdr;
			hdr_rec.last <= 1'b1;
			xact_rec <= pend_xact;
			xact_rec.last <= 1'b1;
		end
	end

endmodule

//--- hw/sync_fifo.sv
module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 4
) (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input payload_t wr_data,
	input logic rd_en,
	output payload_t rd_data,
	output logic full,
	output logic empty,
	output logic almost_full
);
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int lvl_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [lvl_w-1:0] level;
	logic do_wr;
	logic do_rd;

	// Pointer step with wrap at the last entry
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	// Writes into a full FIFO and reads from an empty one are ignored
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Status from the level counter
	assign full = (level == lvl_w'(depth));
	assign empty = (level == '0);
	// Fewer than eight entries free
	assign almost_full = (int'(level) + 8 > depth);

	// Show-ahead output with the head entry always visible
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Level moves only when one side acts alone
			if (do_wr && !do_rd) begin
				level <= level + 1'b1;
			end else if (do_rd && !do_wr) begin
				level <= level - 1'b1;
			end
		end
	end

	// Storage array
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

//--- hw/lb_pkg.sv
`include "gate_defines.svh"

package lb_pkg;

	// One decoded transaction for the bus master
	// rd comes from the read bit of the control word
	// ctl keeps the whole control/address word as received
	// last is set on the final transaction of a packet
	typedef struct packed {
		logic rd;
		logic [`GATE_ADDR_W-1:0] addr;
		logic [`GATE_DATA_W-1:0] wdata;
		logic [`GATE_DATA_W-1:0] ctl;
		logic last;
	} lb_xact_t;

	// Part of a transaction that is echoed in the reply
	// The control/address word goes back unchanged
	typedef struct packed {
		logic [`GATE_DATA_W-1:0] ctl;
		logic last;
	} lb_header_t;

	// Result word of one transaction
	// Read data for a read, the written data for a write
	typedef struct packed {
		logic [`GATE_DATA_W-1:0] data;
	} lb_result_t;

endpackage

//--- hw/stream_pkg.sv
package stream_pkg;

	// One byte of a byte stream
	// last marks the final byte of a reply
	typedef struct packed {
		logic [7:0] data;
		logic last;
	} byte_beat_t;

	// Kind of event seen on the receive side
	// ECHO_NONCE carries a nonce byte back toward the host
	// ECHO_END marks the end of the received packet
	typedef enum logic {
		ECHO_NONCE = 1'b0,
		ECHO_END = 1'b1
	} echo_kind_t;

endpackage

//--- hw/gate_defines.svh
`ifndef GATE_DEFINES_SVH
`define GATE_DEFINES_SVH

// Local bus address width
// Matches bits 23..0 of the control word
`define GATE_ADDR_W 24

// Local bus data width
// A transaction is one control word plus one data word
`define GATE_DATA_W 32

// Largest number of transactions a host may put in one packet
// The header and result FIFOs hold this many entries
`define GATE_MAX_XACT 4

// Entries in the transaction FIFO in front of the bus master
`define GATE_XACT_DEPTH 4

// Bytes in the outgoing reply FIFO
// Room for the nonce echo plus all replies of a full packet
`define GATE_REPLY_DEPTH 64

// Read flag position inside the control word
`define GATE_READ_BIT 28

`endif
